// File: rtl/execute_stage.sv
//####################################################################
// Execute stage
// Circular data stack with ALU, applies one command per cycle and
// drives the LED lines, the emit strobe and the 0branch result
//####################################################################

`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input  wire                                  clk,
	input  wire                                  reset,
	input  forth_core_pkg::exec_cmd_t            cmd,
	output forth_core_pkg::branch_res_t          branch_res,
	output logic [forth_core_pkg::LED_WIDTH-1:0] led,
	output logic                                 emit_valid,
	output logic [forth_core_pkg::EMIT_WIDTH-1:0] emit_data
);

	forth_isa_pkg::cell_t dstack [forth_core_pkg::DSTACK_DEPTH];
	// Points at the top entry
	forth_core_pkg::dsp_t dsp;
	forth_core_pkg::dsp_t dsp_up;
	forth_core_pkg::dsp_t dsp_dn;
	forth_isa_pkg::cell_t tos;
	forth_isa_pkg::cell_t nos;
	forth_isa_pkg::cell_t alu_res;
	// Two operands in, one out
	logic is_binary;
	// Top replaced in place
	logic is_unary;

	assign dsp_up = dsp + 1'b1;
	assign dsp_dn = dsp - 1'b1;
	assign tos = dstack[dsp];
	assign nos = dstack[dsp_dn];

	// ALU, comparisons give all ones for true
	always_comb begin
		alu_res = tos;
		is_binary = 1'b0;
		is_unary = 1'b0;
		case (cmd.op)
			forth_isa_pkg::op_plus: begin
				alu_res = nos + tos;
				is_binary = 1'b1;
			end
			forth_isa_pkg::op_minus: begin
				alu_res = nos - tos;
				is_binary = 1'b1;
			end
			forth_isa_pkg::op_and: begin
				alu_res = nos & tos;
				is_binary = 1'b1;
			end
			forth_isa_pkg::op_or: begin
				alu_res = nos | tos;
				is_binary = 1'b1;
			end
			forth_isa_pkg::op_xor: begin
				alu_res = nos ^ tos;
				is_binary = 1'b1;
			end
			forth_isa_pkg::op_equal: begin
				alu_res = {forth_isa_pkg::CELL_WIDTH{nos == tos}};
				is_binary = 1'b1;
			end
			forth_isa_pkg::op_one_plus: begin
				alu_res = tos + 1'b1;
				is_unary = 1'b1;
			end
			forth_isa_pkg::op_one_minus: begin
				alu_res = tos - 1'b1;
				is_unary = 1'b1;
			end
			forth_isa_pkg::op_not: begin
				alu_res = ~tos;
				is_unary = 1'b1;
			end
			forth_isa_pkg::op_negate: begin
				alu_res = -tos;
				is_unary = 1'b1;
			end
			forth_isa_pkg::op_zero_equal: begin
				alu_res = {forth_isa_pkg::CELL_WIDTH{tos == '0}};
				is_unary = 1'b1;
			end
			forth_isa_pkg::op_zero_less_than: begin
				// Sign bit alone decides
				alu_res = {forth_isa_pkg::CELL_WIDTH{tos[forth_isa_pkg::CELL_WIDTH-1]}};
				is_unary = 1'b1;
			end
			default: ;
		endcase
	end

	// Stack contents, swap is the only double write
	always_ff @(posedge clk) begin
		if (cmd.valid) begin
			case (cmd.op)
				forth_isa_pkg::op_lit:  dstack[dsp_up] <= cmd.operand;
				forth_isa_pkg::op_dup:  dstack[dsp_up] <= tos;
				forth_isa_pkg::op_over: dstack[dsp_up] <= nos;
				forth_isa_pkg::op_swap: begin
					dstack[dsp] <= nos;
					dstack[dsp_dn] <= tos;
				end
				default: begin
					if (is_binary) begin
						dstack[dsp_dn] <= alu_res;
					end
					else if (is_unary) begin
						dstack[dsp] <= alu_res;
					end
				end
			endcase
			if (cmd.op == forth_isa_pkg::op_emit) begin
				emit_data <= tos[forth_core_pkg::EMIT_WIDTH-1:0];
			end
		end
	end

	// Pointer, LED lines and strobes
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			dsp <= '0;
			led <= '0;
			emit_valid <= 1'b0;
			branch_res <= '0;
		end
		else begin
			emit_valid <= 1'b0;
			branch_res <= '0;
			if (cmd.valid) begin
				case (cmd.op)
					forth_isa_pkg::op_lit,
					forth_isa_pkg::op_dup,
					forth_isa_pkg::op_over: dsp <= dsp_up;
					forth_isa_pkg::op_drop: dsp <= dsp_dn;
					forth_isa_pkg::op_io_led: begin
						led <= tos[forth_core_pkg::LED_WIDTH-1:0];
						dsp <= dsp_dn;
					end
					forth_isa_pkg::op_emit: begin
						emit_valid <= 1'b1;
						dsp <= dsp_dn;
					end
					forth_isa_pkg::op_zero_branch: begin
						branch_res.valid <= 1'b1;
						branch_res.taken <= (tos == '0);
						dsp <= dsp_dn;
					end
					default: begin
						if (is_binary) begin
							dsp <= dsp_dn;
						end
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
//####################################################################
// Fetch stage
// Program counter, return stack and operand gathering; resolves
// branch, call and exit locally and waits on execute for 0branch
//####################################################################

`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         start,
	input  forth_isa_pkg::cell_t        rd_data,
	input  forth_core_pkg::branch_res_t branch_res,
	output forth_core_pkg::addr_t       rd_addr,
	output forth_core_pkg::exec_cmd_t   cmd,
	output logic                        done
);

	typedef enum logic [1:0] {
		st_idle,
		st_stream,
		st_operand,
		st_wait_branch
	} fetch_state_e;

	fetch_state_e state;
	// Address on the memory port; always one past the cell in rd_data
	forth_core_pkg::addr_t pc;
	// rd_data holds a cell that was not squashed by a redirect
	logic cell_valid;
	forth_core_pkg::addr_t rstack [forth_core_pkg::RSTACK_DEPTH];
	forth_core_pkg::rsp_t rsp;
	forth_core_pkg::rsp_t rsp_dn;
	// Fill level, saturates once the ring wraps
	logic [forth_core_pkg::RSP_WIDTH:0] rdepth;
	forth_isa_pkg::op_e pend_op;
	forth_core_pkg::addr_t branch_target;
	forth_isa_pkg::op_e cell_op;
	logic is_call;
	logic is_ctrl;
	logic decode;
	logic push_ret;
	logic pop_ret;

	assign rd_addr = pc;
	assign rsp_dn = rsp - 1'b1;

	// Decode of the arriving cell
	assign cell_op = forth_isa_pkg::op_e'(rd_data[forth_isa_pkg::OPCODE_WIDTH-1:0]);
	assign is_call = rd_data[forth_isa_pkg::CALL_BIT];
	assign is_ctrl = cell_op inside {forth_isa_pkg::op_lit, forth_isa_pkg::op_branch,
		forth_isa_pkg::op_zero_branch, forth_isa_pkg::op_exit};
	assign decode = (state == st_stream) && cell_valid;
	assign push_ret = decode && is_call;
	assign pop_ret = decode && !is_call && (cell_op == forth_isa_pkg::op_exit) && (rdepth != '0);

	// Plain opcodes go straight out, lit and 0branch once the operand is here
	always_comb begin
		cmd = '0;
		if (decode && !is_call && !is_ctrl) begin
			cmd.valid = 1'b1;
			cmd.op = cell_op;
		end
		else if (state == st_operand && pend_op != forth_isa_pkg::op_branch) begin
			cmd.valid = 1'b1;
			cmd.op = pend_op;
			cmd.operand = rd_data;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= st_idle;
			pc <= '0;
			cell_valid <= 1'b0;
			rsp <= '0;
			rdepth <= '0;
			done <= 1'b1;
		end
		else if (start) begin
			// Run from address 0 with an empty return stack
			state <= st_stream;
			pc <= '0;
			cell_valid <= 1'b0;
			rsp <= '0;
			rdepth <= '0;
			done <= 1'b0;
		end
		else begin
			// Default is sequential fetch
			pc <= pc + 1'b1;
			cell_valid <= 1'b1;
			case (state)
				st_idle: begin
					pc <= pc;
					cell_valid <= 1'b0;
				end
				st_stream: begin
					if (push_ret) begin
						rsp <= rsp + 1'b1;
						if (rdepth != forth_core_pkg::RSTACK_DEPTH) begin
							rdepth <= rdepth + 1'b1;
						end
						pc <= rd_data[forth_core_pkg::ADDR_WIDTH-1:0];
						cell_valid <= 1'b0;
					end
					else if (decode && cell_op == forth_isa_pkg::op_exit) begin
						cell_valid <= 1'b0;
						if (pop_ret) begin
							rsp <= rsp_dn;
							rdepth <= rdepth - 1'b1;
							pc <= rstack[rsp_dn];
						end
						else begin
							// Exit from the outermost word ends the run
							state <= st_idle;
							done <= 1'b1;
						end
					end
					else if (decode && is_ctrl) begin
						state <= st_operand;
					end
				end
				st_operand: begin
					state <= st_stream;
					if (pend_op == forth_isa_pkg::op_branch) begin
						pc <= rd_data[forth_core_pkg::ADDR_WIDTH-1:0];
						cell_valid <= 1'b0;
					end
					else if (pend_op == forth_isa_pkg::op_zero_branch) begin
						// Hold the fall-through address until execute answers
						state <= st_wait_branch;
						pc <= pc;
						cell_valid <= 1'b0;
					end
				end
				st_wait_branch: begin
					if (!branch_res.valid) begin
						pc <= pc;
						cell_valid <= 1'b0;
					end
					else begin
						state <= st_stream;
						if (branch_res.taken) begin
							pc <= branch_target;
							cell_valid <= 1'b0;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Return addresses, pending opcode and 0branch target
	always_ff @(posedge clk) begin
		if (push_ret) begin
			rstack[rsp] <= pc;
		end
		if (decode) begin
			pend_op <= cell_op;
		end
		if (state == st_operand) begin
			branch_target <= rd_data[forth_core_pkg::ADDR_WIDTH-1:0];
		end
	end

endmodule

`default_nettype wire

// File: rtl/forth_core.sv
//####################################################################
// Forth inner interpreter core
// Program memory feeding the fetch stage, which issues commands to
// the execute stage; load port, start/done, LEDs and emit strobe
//####################################################################

`timescale 1ns/1ns
`default_nettype none

module forth_core (
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire                                  prog_we,
	input  forth_core_pkg::addr_t                prog_addr,
	input  forth_isa_pkg::cell_t                 prog_data,
	input  wire                                  start,
	output logic                                 done,
	output logic [forth_core_pkg::LED_WIDTH-1:0] led,
	output logic                                 emit_valid,
	output logic [forth_core_pkg::EMIT_WIDTH-1:0] emit_data
);

	forth_core_pkg::addr_t rd_addr;
	forth_isa_pkg::cell_t rd_data;
	forth_core_pkg::exec_cmd_t cmd;
	forth_core_pkg::branch_res_t branch_res;

	program_memory u_program_memory (
		.clk     (clk),
		.we      (prog_we),
		.wr_addr (prog_addr),
		.wr_data (prog_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	fetch_stage u_fetch_stage (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.rd_data    (rd_data),
		.branch_res (branch_res),
		.rd_addr    (rd_addr),
		.cmd        (cmd),
		.done       (done)
	);

	execute_stage u_execute_stage (
		.clk        (clk),
		.reset      (reset),
		.cmd        (cmd),
		.branch_res (branch_res),
		.led        (led),
		.emit_valid (emit_valid),
		.emit_data  (emit_data)
	);

endmodule

`default_nettype wire

// File: rtl/forth_core_pkg.sv
//####################################################################
// Forth core machine sizes
// Program address and stack pointer types, plus the records
// passed between the fetch and execute stages
//####################################################################

`default_nettype none

package forth_core_pkg;

	// Program memory
	localparam int ADDR_WIDTH = 10;
	localparam int MEM_DEPTH = 1 << ADDR_WIDTH;

	// Circular stacks, no overflow detection
	localparam int DSTACK_DEPTH = 16;
	localparam int RSTACK_DEPTH = 8;
	localparam int DSP_WIDTH = $clog2(DSTACK_DEPTH);
	localparam int RSP_WIDTH = $clog2(RSTACK_DEPTH);

	// Outputs
	localparam int LED_WIDTH = 3;
	localparam int EMIT_WIDTH = 8;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DSP_WIDTH-1:0] dsp_t;
	typedef logic [RSP_WIDTH-1:0] rsp_t;

	// Fetch to execute, one command per cycle at most
	typedef struct packed {
		logic                 valid;
		forth_isa_pkg::op_e   op;
		// Literal value, or 0branch target in the low address bits
		forth_isa_pkg::cell_t operand;
	} exec_cmd_t;

	// Execute to fetch, resolved 0branch
	typedef struct packed {
		logic valid;
		// Popped value was zero
		logic taken;
	} branch_res_t;

endpackage

`default_nettype wire

// File: rtl/forth_isa_pkg.sv
//####################################################################
// Forth instruction set
// Cell type, code-cell layout and the opcode encoding shared by the
// fetch and execute stages of the inner interpreter
//####################################################################

`default_nettype none

package forth_isa_pkg;

	// One stack or memory cell
	localparam int CELL_WIDTH = 32;

	// Low half of a code cell carries the opcode
	localparam int OPCODE_WIDTH = 16;

	// Set in a code cell means call to the address in its low bits
	localparam int CALL_BIT = 31;

	typedef logic [CELL_WIDTH-1:0] cell_t;

	// Kept opcodes, values fixed so programs stay portable
	typedef enum logic [OPCODE_WIDTH-1:0] {
		op_lit            = 16'd0,
		op_dup            = 16'd1,
		op_drop           = 16'd2,
		op_over           = 16'd3,
		op_swap           = 16'd4,
		op_plus           = 16'd5,
		op_minus          = 16'd6,
		op_one_plus       = 16'd7,
		op_one_minus      = 16'd8,
		op_and            = 16'd9,
		op_or             = 16'd10,
		op_xor            = 16'd11,
		op_not            = 16'd12,
		op_negate         = 16'd13,
		op_equal          = 16'd14,
		op_zero_equal     = 16'd15,
		op_zero_less_than = 16'd16,
		// Control flow, resolved in fetch except 0branch
		op_branch         = 16'd17,
		op_zero_branch    = 16'd18,
		op_exit           = 16'd19,
		// Outputs
		op_io_led         = 16'd20,
		op_emit           = 16'd21
	} op_e;

endpackage

`default_nettype wire

// File: rtl/program_memory.sv
//####################################################################
// Program memory
// 1024 cells, one write port for loading, synchronous read for fetch
//####################################################################

`timescale 1ns/1ns
`default_nettype none

module program_memory (
	input  wire                   clk,
	input  wire                   we,
	input  forth_core_pkg::addr_t wr_addr,
	input  forth_isa_pkg::cell_t  wr_data,
	input  forth_core_pkg::addr_t rd_addr,
	output forth_isa_pkg::cell_t  rd_data
);

	forth_isa_pkg::cell_t mem [forth_core_pkg::MEM_DEPTH];

	// Load port, only used while the core sits idle
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Read data lands one cycle after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: tb.f
rtl/forth_isa_pkg.sv
rtl/forth_core_pkg.sv
rtl/program_memory.sv
rtl/fetch_stage.sv
rtl/execute_stage.sv
rtl/forth_core.sv
verification/forth_core_asserts.sv
verification/forth_core_tb.sv

// File: verification/forth_core_asserts.sv
//####################################################################
// Forth core protocol checks
// Concurrent assertions on the emit strobe and the done level,
// bound into the core top level
//####################################################################

`timescale 1ns/1ns
`default_nettype none

module forth_core_asserts (
	input wire clk,
	input wire reset,
	input wire start,
	input wire done,
	input wire emit_valid
);

	// Number of failed assertions
	int fail_count = 0;

	// Emit is a single-cycle pulse
	emit_single_cycle: assert property (@(posedge clk) disable iff (!reset)
		emit_valid |=> !emit_valid)
	else begin
		fail_count++;
		$error("emit_valid high for two cycles in a row");
	end

	// Done only drops right after start
	done_falls_on_start: assert property (@(posedge clk) disable iff (!reset)
		$fell(done) |-> $past(start))
	else begin
		fail_count++;
		$error("done fell without a start in the previous cycle");
	end

	// Idle core never emits
	no_emit_when_idle: assert property (@(posedge clk) disable iff (!reset)
		!(emit_valid && done))
	else begin
		fail_count++;
		$error("emit_valid high while done is high");
	end

endmodule

bind forth_core forth_core_asserts u_asserts (
	.clk        (clk),
	.reset      (reset),
	.start      (start),
	.done       (done),
	.emit_valid (emit_valid)
);

`default_nettype wire

// File: verification/forth_core_tb.sv
//####################################################################
// Forth core testbench
// Loads small programs through the load port, runs them and compares
// emitted bytes and LED lines with a software interpreter
//####################################################################

`timescale 1ns/1ns
`default_nettype none

module forth_core_tb;

	localparam int CLK_PERIOD = 8;
	// Cycles allowed per program cell to cover loading and loops
	localparam int LOOP_BOUND = 40;
	localparam int DS = forth_core_pkg::DSTACK_DEPTH;
	localparam int RS = forth_core_pkg::RSTACK_DEPTH;
	localparam int LW = forth_core_pkg::LED_WIDTH;
	localparam int EW = forth_core_pkg::EMIT_WIDTH;
	// Opcode outside the set that executes as nothing
	localparam forth_isa_pkg::cell_t NOP_CELL = 32'h0000_00ff;
	localparam forth_isa_pkg::op_e ALU_OPS [12] = '{
		forth_isa_pkg::op_plus, forth_isa_pkg::op_minus, forth_isa_pkg::op_one_plus,
		forth_isa_pkg::op_one_minus, forth_isa_pkg::op_and, forth_isa_pkg::op_or,
		forth_isa_pkg::op_xor, forth_isa_pkg::op_not, forth_isa_pkg::op_negate,
		forth_isa_pkg::op_equal, forth_isa_pkg::op_zero_equal,
		forth_isa_pkg::op_zero_less_than
	};

	logic clk;
	logic reset;
	logic prog_we;
	forth_core_pkg::addr_t prog_addr;
	forth_isa_pkg::cell_t prog_data;
	logic start;
	logic done;
	logic [LW-1:0] led;
	logic emit_valid;
	logic [EW-1:0] emit_data;

	// Program under construction and expected bytes in order
	forth_isa_pkg::cell_t prog [$];
	logic [EW-1:0] exp_q [$];
	logic [LW-1:0] model_led = '0;
	int errors = 0;
	// Watchdog limit in cycles that grows with every program run
	int wd_budget = 64;

	forth_core dut (
		.clk        (clk),
		.reset      (reset),
		.prog_we    (prog_we),
		.prog_addr  (prog_addr),
		.prog_data  (prog_data),
		.start      (start),
		.done       (done),
		.led        (led),
		.emit_valid (emit_valid),
		.emit_data  (emit_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic void append_cell(input forth_isa_pkg::cell_t c);
		prog.push_back(c);
	endfunction

	function automatic void put_op(input forth_isa_pkg::op_e op);
		append_cell({16'h0000, op});
	endfunction

	function automatic void put_lit(input forth_isa_pkg::cell_t v);
		put_op(forth_isa_pkg::op_lit);
		append_cell(v);
	endfunction

	// Spacer keeps emit strobes apart
	function automatic void put_emit();
		put_op(forth_isa_pkg::op_emit);
		append_cell(NOP_CELL);
	endfunction

	function automatic forth_isa_pkg::cell_t call_cell(input int target);
		forth_isa_pkg::cell_t c;
		c = '0;
		c[forth_isa_pkg::CALL_BIT] = 1'b1;
		c[forth_core_pkg::ADDR_WIDTH-1:0] = forth_core_pkg::addr_t'(target);
		return c;
	endfunction

	// Software interpreter that fills exp_q and returns the final LED value
	function automatic logic [LW-1:0] run_model();
		forth_isa_pkg::cell_t ds [DS];
		int rs [RS];
		int dp;
		int rp;
		int depth;
		int pc;
		forth_isa_pkg::cell_t c;
		forth_isa_pkg::cell_t a;
		forth_isa_pkg::cell_t b;
		forth_isa_pkg::op_e op;
		dp = 0;
		rp = 0;
		depth = 0;
		pc = 0;
		for (int steps = 0; steps < prog.size() * LOOP_BOUND; steps++) begin
			c = prog[pc];
			pc++;
			op = forth_isa_pkg::op_e'(c[15:0]);
			if (c[forth_isa_pkg::CALL_BIT]) begin
				rs[rp] = pc;
				rp = (rp + 1) % RS;
				depth++;
				pc = int'(c[forth_core_pkg::ADDR_WIDTH-1:0]);
			end
			else begin
				case (op)
					forth_isa_pkg::op_lit: begin
						dp = (dp + 1) % DS;
						ds[dp] = prog[pc];
						pc++;
					end
					forth_isa_pkg::op_dup, forth_isa_pkg::op_over: begin
						a = (op == forth_isa_pkg::op_dup) ? ds[dp] : ds[(dp + DS - 1) % DS];
						dp = (dp + 1) % DS;
						ds[dp] = a;
					end
					forth_isa_pkg::op_drop: dp = (dp + DS - 1) % DS;
					forth_isa_pkg::op_swap: begin
						a = ds[dp];
						ds[dp] = ds[(dp + DS - 1) % DS];
						ds[(dp + DS - 1) % DS] = a;
					end
					forth_isa_pkg::op_plus, forth_isa_pkg::op_minus, forth_isa_pkg::op_and,
					forth_isa_pkg::op_or, forth_isa_pkg::op_xor, forth_isa_pkg::op_equal: begin
						// Second operand is on top
						b = ds[dp];
						dp = (dp + DS - 1) % DS;
						a = ds[dp];
						case (op)
							forth_isa_pkg::op_plus:  ds[dp] = a + b;
							forth_isa_pkg::op_minus: ds[dp] = a - b;
							forth_isa_pkg::op_and:   ds[dp] = a & b;
							forth_isa_pkg::op_or:    ds[dp] = a | b;
							forth_isa_pkg::op_xor:   ds[dp] = a ^ b;
							default:                 ds[dp] = (a == b) ? '1 : '0;
						endcase
					end
					forth_isa_pkg::op_one_plus:       ds[dp] = ds[dp] + 1;
					forth_isa_pkg::op_one_minus:      ds[dp] = ds[dp] - 1;
					forth_isa_pkg::op_not:            ds[dp] = ~ds[dp];
					forth_isa_pkg::op_negate:         ds[dp] = 0 - ds[dp];
					forth_isa_pkg::op_zero_equal:     ds[dp] = (ds[dp] == 0) ? '1 : '0;
					forth_isa_pkg::op_zero_less_than: ds[dp] = ($signed(ds[dp]) < 0) ? '1 : '0;
					forth_isa_pkg::op_branch: begin
						pc = int'(prog[pc][forth_core_pkg::ADDR_WIDTH-1:0]);
					end
					forth_isa_pkg::op_zero_branch: begin
						a = ds[dp];
						dp = (dp + DS - 1) % DS;
						pc = (a == 0) ? int'(prog[pc][forth_core_pkg::ADDR_WIDTH-1:0]) : pc + 1;
					end
					forth_isa_pkg::op_exit: begin
						// Outermost exit ends the program
						if (depth == 0) begin
							return model_led;
						end
						rp = (rp + RS - 1) % RS;
						pc = rs[rp];
						depth--;
					end
					forth_isa_pkg::op_io_led: begin
						model_led = ds[dp][LW-1:0];
						dp = (dp + DS - 1) % DS;
					end
					forth_isa_pkg::op_emit: begin
						exp_q.push_back(ds[dp][EW-1:0]);
						dp = (dp + DS - 1) % DS;
					end
					default: ;
				endcase
			end
		end
		errors++;
		$display("Reference model never reached the final exit of the program");
		return model_led;
	endfunction

	task automatic check_emit(input logic [EW-1:0] got, input logic [EW-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: emit_data 0x%02h, expected 0x%02h", $time, got, exp);
		end
	endtask

	task automatic check_led(input logic [LW-1:0] got, input logic [LW-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: led %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_done(input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: done %b, expected %b", $time, got, exp);
		end
	endtask

	// Compares each strobed byte against the model's queue in order
	always @(posedge clk) begin
		if (reset && emit_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Extra emit of 0x%02h at %0t ns that the model did not expect",
					emit_data, $time);
			end
			else begin
				check_emit(emit_data, exp_q.pop_front());
			end
		end
	end

	// Load, start, wait for done, then look for missing bytes and the LEDs
	task automatic run_program();
		logic [LW-1:0] want_led;
		wd_budget += prog.size() * LOOP_BOUND;
		want_led = run_model();
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			prog_we <= 1'b1;
			prog_addr <= forth_core_pkg::addr_t'(i);
			prog_data <= prog[i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		check_done(done, 1'b0);
		while (!done) begin
			@(posedge clk);
		end
		@(posedge clk);
		if (exp_q.size() != 0) begin
			errors += exp_q.size();
			$display("Missing emits: %0d expected bytes never appeared", exp_q.size());
			exp_q.delete();
		end
		check_led(led, want_led);
	endtask

	// Watchdog
	initial begin
		int cycles;
		cycles = 0;
		while (cycles <= wd_budget) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", wd_budget);
		$display("Errors: %0d", errors);
		$display("Verification failed");
		$finish;
	end

	initial begin
		int loop_at;
		int zbr_at;
		int call_at [4];
		int word_at [3];
		int assert_fails;
		void'($urandom(32'hacaf_3c3c));
		reset = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		start = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b1;
		// Idle after reset while the comparator flags any early emit
		repeat (3) @(posedge clk);
		check_done(done, 1'b1);
		check_led(led, '0);

		// ALU ops on random values, then on zeros and on all ones for the true results
		prog.delete();
		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < 12; i++) begin
				put_lit((k == 0) ? $urandom() : ((k == 1) ? 32'h0 : 32'hffff_ffff));
				put_lit((k == 0) ? $urandom() : ((k == 1) ? 32'h0 : 32'hffff_ffff));
				put_op(ALU_OPS[i]);
				put_emit();
			end
		end
		put_op(forth_isa_pkg::op_exit);
		run_program();

		// Shuffles then 20 pushes and pops across the stack ring
		prog.delete();
		for (int i = 0; i < 3; i++) begin
			put_lit($urandom());
		end
		put_op(forth_isa_pkg::op_dup);
		put_emit();
		put_op(forth_isa_pkg::op_drop);
		put_op(forth_isa_pkg::op_over);
		put_emit();
		put_op(forth_isa_pkg::op_swap);
		put_emit();
		put_emit();
		for (int i = 0; i < 20; i++) begin
			put_lit($urandom());
		end
		for (int i = 0; i < 20; i++) begin
			put_emit();
		end
		put_op(forth_isa_pkg::op_exit);
		run_program();

		// Countdown loop from 5
		prog.delete();
		put_lit(5);
		loop_at = prog.size();
		put_op(forth_isa_pkg::op_dup);
		put_emit();
		put_op(forth_isa_pkg::op_one_minus);
		put_op(forth_isa_pkg::op_dup);
		put_op(forth_isa_pkg::op_zero_branch);
		zbr_at = prog.size();
		append_cell('0);
		put_op(forth_isa_pkg::op_branch);
		append_cell(loop_at);
		prog[zbr_at] = prog.size();
		put_op(forth_isa_pkg::op_drop);
		put_op(forth_isa_pkg::op_exit);
		run_program();

		// Main calls w2 (two deep) then w1 (three deep)
		prog.delete();
		call_at[0] = prog.size();
		append_cell('0);
		call_at[1] = prog.size();
		append_cell('0);
		put_lit(9);
		put_emit();
		put_op(forth_isa_pkg::op_exit);
		for (int w = 0; w < 3; w++) begin
			word_at[w] = prog.size();
			put_lit(2 * w + 2);
			put_emit();
			if (w < 2) begin
				call_at[w + 2] = prog.size();
				append_cell('0);
				put_lit(2 * w + 3);
				put_emit();
			end
			put_op(forth_isa_pkg::op_exit);
		end
		prog[call_at[0]] = call_cell(word_at[1]);
		prog[call_at[1]] = call_cell(word_at[0]);
		prog[call_at[2]] = call_cell(word_at[1]);
		prog[call_at[3]] = call_cell(word_at[2]);
		run_program();

		// LED lines keep the last io_led value
		prog.delete();
		for (int i = 0; i < 4; i++) begin
			put_lit($urandom());
			put_op(forth_isa_pkg::op_io_led);
		end
		put_op(forth_isa_pkg::op_exit);
		run_program();

		repeat (2) @(posedge clk);
		assert_fails = dut.u_asserts.fail_count;
		$display("Errors: %0d check, %0d assertion", errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Verification passed");
		end
		else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
